// ==== adder_unit.sv ====
// Adder unit for add, subtract and signed or unsigned set-less-than
`timescale 1ns/1ps

module adder_unit
    import exec_op_pkg::*;
(
    input  word_t     first_operand_i,
    input  word_t     second_operand_i,
    input  adder_op_e op_i,
    output word_t     result_o
);

    localparam int W = $bits(word_t);

    logic         is_sub;
    word_t        addend;
    logic [W:0]   sum;         // Carry in the top bit
    logic         lt_signed;
    logic         lt_unsigned;

    assign is_sub = (op_i == SUB) || (op_i == SLT) || (op_i == SLTU);
    assign addend = is_sub ? ~second_operand_i : second_operand_i;
    assign sum    = {1'b0, first_operand_i} + {1'b0, addend} + {{W{1'b0}}, is_sub};

    assign lt_unsigned = ~sum[W];  // No carry means borrow
    assign lt_signed   = (first_operand_i[W-1] != second_operand_i[W-1]) ?
                         first_operand_i[W-1] : sum[W-1];

    always_comb begin
        case (op_i)
            SLT:     result_o = {{W-1{1'b0}}, lt_signed};
            SLTU:    result_o = {{W-1{1'b0}}, lt_unsigned};
            default: result_o = sum[W-1:0];  // ADD, SUB and spare codes
        endcase
    end

endmodule

// ==== branch_unit.sv ====
// Branch unit that resolves conditions, targets and link values
`timescale 1ns/1ps

module branch_unit
    import exec_op_pkg::*;
(
    input  word_t      first_operand_i,
    input  word_t      second_operand_i,
    input  word_t      offset_i,
    input  word_t      pc_i,
    input  branch_op_e op_i,
    output word_t      link_o,
    output word_t      target_o,
    output logic       jump_o,
    output logic       write_enable_o
);

    logic  equal;
    logic  less_signed;
    logic  less_unsigned;
    word_t jalr_sum;

    assign equal         = first_operand_i == second_operand_i;
    assign less_signed   = $signed(first_operand_i) < $signed(second_operand_i);
    assign less_unsigned = first_operand_i < second_operand_i;

    assign jalr_sum = first_operand_i + offset_i;

    assign link_o = pc_i + word_t'(4);  // Return address

    // Jalr target is register based with bit 0 cleared
    assign target_o = (op_i == JALR) ? {jalr_sum[$bits(word_t)-1:1], 1'b0} :
                                       pc_i + offset_i;

    assign write_enable_o = (op_i == JAL) || (op_i == JALR);

    always_comb begin
        jump_o = 1'b0;
        case (op_i)
            BEQ:  jump_o = equal;
            BNE:  jump_o = ~equal;
            BLT:  jump_o = less_signed;
            BGE:  jump_o = ~less_signed;
            BLTU: jump_o = less_unsigned;
            BGEU: jump_o = ~less_unsigned;
            JAL,
            JALR: jump_o = 1'b1;  // Always taken
            default: jump_o = 1'b0;
        endcase
    end

endmodule

// ==== exec_config.svh ====
// Execute stage configuration: data, tag and operation-code field widths
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

`define XLEN    32  // Data word width
`define TAG_W   3   // Instruction tag width

// Operation code layout, unit field above sub-operation field
`define UNIT_W  3
`define SUBOP_W 3

`endif

// ==== exec_op_pkg.sv ====
// Operation encoding for the execute stage: units, sub-operations and input bundle
package exec_op_pkg;

`include "exec_config.svh"

    typedef logic [`XLEN-1:0]             word_t;    // Operands, pc and results
    typedef logic [`TAG_W-1:0]            tag_t;     // Instruction tag
    typedef logic [`UNIT_W+`SUBOP_W-1:0]  exec_op_t; // {unit, sub-operation}

    // Unit field of the operation code, 5 to 7 are illegal
    typedef enum logic [`UNIT_W-1:0] {
        ADDER  = 3'd0,
        LOGIC  = 3'd1,
        SHIFT  = 3'd2,
        BRANCH = 3'd3,
        BYPASS = 3'd4
    } exec_unit_e;

    typedef enum logic [`SUBOP_W-1:0] {
        ADD  = 3'd0,
        SUB  = 3'd1,
        SLT  = 3'd2,
        SLTU = 3'd3     // Codes 4 to 7 act as ADD
    } adder_op_e;

    // Shared code for logic and shift, filled in by the decoder
    typedef enum logic [`SUBOP_W-1:0] {AND, OR, XOR, SLL, SRL, SRA} lshift_op_e;

    typedef enum logic [`SUBOP_W-1:0] {BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR} branch_op_e;

    // One decoded instruction, 137 bits
    typedef struct packed {
        exec_op_t op;
        word_t    pc;
        word_t    first_operand;
        word_t    second_operand;
        word_t    third_operand;    // Branch offset
        tag_t     tag;
    } exec_in_t;

endpackage

// ==== exec_result_pkg.sv ====
// Retirement format produced by the execute stage
package exec_result_pkg;

    //////////////////////////////////////////////////
    // Output bundle towards retirement
    //////////////////////////////////////////////////

    typedef struct packed {
        exec_op_pkg::word_t result0;      // Unit result or link address
        exec_op_pkg::word_t result1;      // Branch target, else zero
        logic               jump;         // Taken control transfer
        logic               write_enable; // Register bank write
        logic               illegal;      // Unknown unit code
        exec_op_pkg::tag_t  tag;
        exec_op_pkg::word_t pc;
    } exec_out_t;

    // Note that reset clears every field, so a cleared
    // bundle is a bubble that neither writes nor jumps

endpackage

// ==== execute_checker.sv ====
// Execute stage checker with a reference model and concurrent assertions on every output
`timescale 1ns/1ps

`include "exec_config.svh"

module execute_checker
    import exec_op_pkg::*;
    import exec_result_pkg::*;
(
    input logic      clk,
    input logic      reset_i,
    input logic      stall_i,
    input exec_in_t  in_i,
    input exec_out_t out_i
);

    logic [`UNIT_W-1:0]  unit;
    logic [`SUBOP_W-1:0] subop;
    word_t               a;
    word_t               b;
    exec_out_t           expect_next;
    exec_out_t           model_q;           // Expected output register
    logic                primed = 1'b0;     // Set once reset has been seen
    int unsigned         failures = 0;

    //////////////////////////////////////////////////
    // Reference model from the selection rules
    //////////////////////////////////////////////////

    always_comb begin
        unit  = in_i.op[`UNIT_W+`SUBOP_W-1:`SUBOP_W];
        subop = in_i.op[`SUBOP_W-1:0];
        a     = in_i.first_operand;
        b     = in_i.second_operand;
        expect_next     = '0;
        expect_next.tag = in_i.tag;
        expect_next.pc  = in_i.pc;
        expect_next.write_enable = 1'b1;
        case (unit)
            ADDER: begin
                case (subop)
                    3'd1:    expect_next.result0 = a - b;
                    3'd2:    expect_next.result0 = word_t'($signed(a) < $signed(b));
                    3'd3:    expect_next.result0 = word_t'(a < b);
                    default: expect_next.result0 = a + b;
                endcase
            end
            LOGIC: begin
                case (subop)
                    3'd1:    expect_next.result0 = a | b;
                    3'd2:    expect_next.result0 = a ^ b;
                    default: expect_next.result0 = a & b;
                endcase
            end
            SHIFT: begin
                case (subop)
                    3'd1:    expect_next.result0 = a >> b[4:0];
                    3'd2:    expect_next.result0 = $signed(a) >>> b[4:0];
                    default: expect_next.result0 = a << b[4:0];
                endcase
            end
            BYPASS: expect_next.result0 = b;
            BRANCH: begin
                expect_next.result0      = in_i.pc + 32'd4;  // Link address
                expect_next.result1      = in_i.pc + in_i.third_operand;
                expect_next.write_enable = 1'b0;
                case (branch_op_e'(subop))
                    BEQ:  expect_next.jump = (a == b);
                    BNE:  expect_next.jump = (a != b);
                    BLT:  expect_next.jump = ($signed(a) < $signed(b));
                    BGE:  expect_next.jump = ($signed(a) >= $signed(b));
                    BLTU: expect_next.jump = (a < b);
                    BGEU: expect_next.jump = (a >= b);
                    default: begin                            // JAL and JALR
                        expect_next.jump         = 1'b1;
                        expect_next.write_enable = 1'b1;
                    end
                endcase
                if (subop == 3'd7) begin
                    expect_next.result1 = (a + in_i.third_operand) & ~word_t'(1);
                end
            end
            default: begin
                expect_next.write_enable = 1'b0;
                expect_next.illegal      = 1'b1;  // Unit codes 5 to 7
            end
        endcase
    end

    always @(posedge clk) begin
        if (reset_i) begin
            model_q <= '0;
            primed  <= 1'b1;
        end else if (!stall_i) begin
            model_q <= expect_next;
        end
    end

    //////////////////////////////////////////////////
    // Assertions
    //////////////////////////////////////////////////

    a_reset_clear: assert property (@(posedge clk) reset_i |=> out_i == '0)
        else begin failures = failures + 1; $error("Output not cleared after reset"); end

    a_result_words: assert property (@(posedge clk) primed |->
        (out_i.result0 == model_q.result0 && out_i.result1 == model_q.result1))
        else begin failures = failures + 1; $error("Result words differ from model"); end

    a_control_flags: assert property (@(posedge clk) primed |->
        (out_i.jump == model_q.jump && out_i.write_enable == model_q.write_enable &&
         out_i.illegal == model_q.illegal))
        else begin failures = failures + 1; $error("Jump, write or illegal flag wrong"); end

    a_tag_pc: assert property (@(posedge clk) primed |->
        (out_i.tag == model_q.tag && out_i.pc == model_q.pc))
        else begin failures = failures + 1; $error("Tag or pc not passed through"); end

    a_stall_hold: assert property (@(posedge clk)
        (primed && stall_i && !reset_i) |=> $stable(out_i))
        else begin failures = failures + 1; $error("Output changed while stalled"); end

    a_illegal_quiet: assert property (@(posedge clk) (primed && out_i.illegal) |->
        (out_i.result0 == '0 && out_i.result1 == '0 && !out_i.jump && !out_i.write_enable))
        else begin failures = failures + 1; $error("Illegal op produced a result"); end

endmodule

bind execute_stage execute_checker u_checker (
    .clk     (clk),
    .reset_i (reset_i),
    .stall_i (stall_i),
    .in_i    (in_i),
    .out_i   (out_o)
);

// ==== execute_stage.sv ====
// Integer execute stage with decoder, three execution units and registered selector
`timescale 1ns/1ps

module execute_stage
    import exec_op_pkg::*;
    import exec_result_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      stall_i,
    input  exec_in_t  in_i,
    output exec_out_t out_o
);

    exec_unit_e unit;
    adder_op_e  adder_op;
    lshift_op_e lshift_op;
    branch_op_e branch_op;
    logic       illegal;
    word_t      adder_result;
    word_t      lshift_result;
    word_t      link;
    word_t      target;
    logic       jump;
    logic       branch_write_enable;

    //////////////////////////////////////////////////
    // Decode and execution units
    //////////////////////////////////////////////////

    operation_decode u_decode (
        .op_i        (in_i.op),
        .unit_o      (unit),
        .adder_op_o  (adder_op),
        .lshift_op_o (lshift_op),
        .branch_op_o (branch_op),
        .illegal_o   (illegal)
    );

    adder_unit u_adder (
        .first_operand_i  (in_i.first_operand),
        .second_operand_i (in_i.second_operand),
        .op_i             (adder_op),
        .result_o         (adder_result)
    );

    logic_shift_unit u_logic_shift (
        .first_operand_i  (in_i.first_operand),
        .second_operand_i (in_i.second_operand),
        .op_i             (lshift_op),
        .result_o         (lshift_result)
    );

    branch_unit u_branch (
        .first_operand_i  (in_i.first_operand),
        .second_operand_i (in_i.second_operand),
        .offset_i         (in_i.third_operand),
        .pc_i             (in_i.pc),
        .op_i             (branch_op),
        .link_o           (link),
        .target_o         (target),
        .jump_o           (jump),
        .write_enable_o   (branch_write_enable)
    );

    //////////////////////////////////////////////////
    // Retirement register
    //////////////////////////////////////////////////

    result_select u_select (
        .clk                   (clk),
        .reset_i               (reset_i),
        .stall_i               (stall_i),
        .unit_i                (unit),
        .illegal_i             (illegal),
        .adder_result_i        (adder_result),
        .lshift_result_i       (lshift_result),
        .bypass_i              (in_i.second_operand),  // Bypass path
        .link_i                (link),
        .target_i              (target),
        .jump_i                (jump),
        .branch_write_enable_i (branch_write_enable),
        .tag_i                 (in_i.tag),
        .pc_i                  (in_i.pc),
        .out_o                 (out_o)
    );

endmodule

// ==== files.f ====
+incdir+.
exec_op_pkg.sv
exec_result_pkg.sv
operation_decode.sv
adder_unit.sv
logic_shift_unit.sv
branch_unit.sv
result_select.sv
execute_stage.sv
execute_checker.sv
tb_execute.sv

// ==== logic_shift_unit.sv ====
// Logic and shift unit for and, or, xor and the three shifts
`timescale 1ns/1ps

module logic_shift_unit
    import exec_op_pkg::*;
(
    input  word_t      first_operand_i,
    input  word_t      second_operand_i,
    input  lshift_op_e op_i,
    output word_t      result_o
);

    localparam int SHAMT_W = $clog2($bits(word_t));

    logic [SHAMT_W-1:0] shamt;
    word_t              sra_result;

    assign shamt      = second_operand_i[SHAMT_W-1:0];  // Low 5 bits only
    assign sra_result = word_t'($signed(first_operand_i) >>> shamt);

    //////////////////////////////////////////////////
    // Operation mux
    //////////////////////////////////////////////////

    always_comb begin
        case (op_i)
            AND: begin
                result_o = first_operand_i & second_operand_i;
            end
            OR: begin
                result_o = first_operand_i | second_operand_i;
            end
            XOR: begin
                result_o = first_operand_i ^ second_operand_i;
            end
            SLL: begin
                result_o = first_operand_i << shamt;
            end
            SRL: begin
                result_o = first_operand_i >> shamt;  // Zero fill
            end
            SRA: begin
                result_o = sra_result;                // Sign fill
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// ==== operation_decode.sv ====
// Operation decoder that splits the op code into unit selector and sub-operations
`timescale 1ns/1ps

`include "exec_config.svh"

module operation_decode
    import exec_op_pkg::*;
(
    input  exec_op_t   op_i,
    output exec_unit_e unit_o,
    output adder_op_e  adder_op_o,
    output lshift_op_e lshift_op_o,
    output branch_op_e branch_op_o,
    output logic       illegal_o
);

    logic [`UNIT_W-1:0]  unit_field;
    logic [`SUBOP_W-1:0] subop;

    assign unit_field = op_i[`UNIT_W+`SUBOP_W-1:`SUBOP_W];
    assign subop      = op_i[`SUBOP_W-1:0];

    assign unit_o      = exec_unit_e'(unit_field);
    assign adder_op_o  = adder_op_e'(subop);
    assign branch_op_o = branch_op_e'(subop);
    assign illegal_o   = unit_field > BYPASS;  // Codes 5 to 7

    // Logic and shift sub-ops 0..2 map onto the shared code
    always_comb begin
        lshift_op_o = AND;
        case (unit_o)
            LOGIC: begin
                if (subop == `SUBOP_W'(1))      lshift_op_o = OR;
                else if (subop == `SUBOP_W'(2)) lshift_op_o = XOR;
                else                             lshift_op_o = AND;  // Unused codes
            end
            SHIFT: begin
                if (subop == `SUBOP_W'(1))      lshift_op_o = SRL;
                else if (subop == `SUBOP_W'(2)) lshift_op_o = SRA;
                else                             lshift_op_o = SLL;  // Unused codes
            end
            default: lshift_op_o = AND;  // Not read by the selector
        endcase
    end

endmodule

// ==== result_select.sv ====
// Result selector that picks the active unit's outputs and registers them
`timescale 1ns/1ps

module result_select
    import exec_op_pkg::*;
    import exec_result_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    input  logic       stall_i,
    input  exec_unit_e unit_i,
    input  logic       illegal_i,
    input  word_t      adder_result_i,
    input  word_t      lshift_result_i,
    input  word_t      bypass_i,
    input  word_t      link_i,
    input  word_t      target_i,
    input  logic       jump_i,
    input  logic       branch_write_enable_i,
    input  tag_t       tag_i,
    input  word_t      pc_i,
    output exec_out_t  out_o
);

    exec_out_t next_out;

    //////////////////////////////////////////////////
    // Selection by unit
    //////////////////////////////////////////////////

    always_comb begin
        next_out     = '0;         // result1 and jump default to zero
        next_out.tag = tag_i;
        next_out.pc  = pc_i;
        if (illegal_i) begin
            next_out.illegal = 1'b1;  // Results stay zero, no write
        end else begin
            unique case (unit_i)
                ADDER: begin
                    next_out.result0      = adder_result_i;
                    next_out.write_enable = 1'b1;
                end
                LOGIC, SHIFT: begin
                    next_out.result0      = lshift_result_i;
                    next_out.write_enable = 1'b1;
                end
                BYPASS: begin
                    next_out.result0      = bypass_i;
                    next_out.write_enable = 1'b1;
                end
                BRANCH: begin
                    next_out.result0      = link_i;
                    next_out.result1      = target_i;
                    next_out.jump         = jump_i;
                    next_out.write_enable = branch_write_enable_i;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            out_o <= '0;           // Wins over stall
        end else if (!stall_i) begin
            out_o <= next_out;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_execute -o tb_execute_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

output=$(./obj_dir/tb_execute_sim +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1

// ==== tb_execute.sv ====
// Testbench for the execute stage with directed branch corners and random stimulus
`timescale 1ns/1ps

`include "exec_config.svh"

module tb_execute
    import exec_op_pkg::*;
    import exec_result_pkg::*;
();

    localparam int RESET_CYCLES    = 5;
    localparam int DIRECTED_CYCLES = 8 * 6;  // Branch ops times corner pairs
    localparam int RANDOM_CYCLES   = 2000;
    localparam int TIMEOUT_CYCLES  = (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES) * 6 / 5;

    logic      clk;
    logic      reset_i;
    logic      stall_i;
    exec_in_t  in_i;
    exec_out_t out_o;
    int        cycle_count = 0;

    // Signed and unsigned compare corners with an equal pair at index 4
    word_t corner_a [6] = '{32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff,
                            32'h0000_0001, 32'h1234_5678, 32'h0000_0000};
    word_t corner_b [6] = '{32'h7fff_ffff, 32'h8000_0000, 32'h0000_0001,
                            32'hffff_ffff, 32'h1234_5678, 32'h8000_0000};

    execute_stage dut (
        .clk     (clk),
        .reset_i (reset_i),
        .stall_i (stall_i),
        .in_i    (in_i),
        .out_o   (out_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // One instruction per rising edge with a word aligned pc
    task automatic drive_input(input exec_op_t op, input word_t a, input word_t b,
                               input logic stall);
        exec_in_t item;
        @(posedge clk);
        item.op             = op;
        item.pc             = word_t'($urandom) & 32'hffff_fffc;
        item.first_operand  = a;
        item.second_operand = b;
        item.third_operand  = word_t'($urandom);
        item.tag            = tag_t'($urandom);
        in_i    <= item;
        stall_i <= stall;
    endtask

    initial begin
        void'($urandom(39));
        reset_i = 1'b1;
        stall_i = 1'b0;
        in_i    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;
        for (int op = 0; op < 8; op++) begin
            for (int k = 0; k < 6; k++) begin
                drive_input({BRANCH, `SUBOP_W'(op)}, corner_a[k], corner_b[k], 1'b0);
            end
        end
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            drive_input(exec_op_t'($urandom), word_t'($urandom), word_t'($urandom),
                        $urandom_range(99) < 20);  // Stall about 20 %
        end
        repeat (3) @(posedge clk);  // Last item checked two edges after it is driven
        if (dut.u_checker.failures != 0) begin
            $display(">>> FAIL");
            $fatal(1, "Checker reported failures");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

    // Checker state is read between edges
    always @(negedge clk) begin
        if (dut.u_checker.failures != 0) begin
            $display("MISMATCH at %0d ns: DUT output differs from the reference model", $time);
            $display(">>> FAIL");
            $fatal(1, "Stopped at first assertion failure");
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $fatal(1, "Timeout");
        end
    end

endmodule
